// ==== hdl/fetch_config.svh ====
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// fetch address width in bits
`define ADDR_W 32

`define ROM_WORDS 256
`define FIFO_DEPTH 16

// first fetch after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== hdl/fetch_pkg.sv ====
`include "fetch_config.svh"

package fetch_pkg;

    typedef struct packed {
        logic               invalid;  // fetch above memory depth
        logic [`ADDR_W-1:0] addr;
        logic [31:0]        data;
    } fifo_entry_t;

    typedef struct packed {
        logic        valid;
        fifo_entry_t entry;
    } issue_slot_t;

    typedef struct packed {
        logic               valid;
        logic [`ADDR_W-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic               psel;
        logic               penable;
        logic               pwrite;
        logic [`ADDR_W-1:0] paddr;
        logic [31:0]        pwdata;
    } apb_req_t;

    typedef struct packed {
        logic pready;
        logic pslverr;
    } apb_rsp_t;

    typedef enum logic [2:0] {OP_ALU, OP_LOAD, OP_STORE, OP_BRANCH, OP_JUMP} op_class_e;

    function automatic op_class_e op_class_of(input logic [31:0] inst);
        logic [5:0] opcode;
        logic [5:0] funct;
        opcode = inst[31:26];
        funct  = inst[5:0];
        case (opcode)
            6'h00:                             // special, jr / jalr jump
                return (funct == 6'h08 || funct == 6'h09) ? OP_JUMP : OP_ALU;
            6'h01, 6'h04, 6'h05, 6'h06, 6'h07: return OP_BRANCH;
            6'h02, 6'h03:                      return OP_JUMP;
            6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26: return OP_LOAD;
            6'h28, 6'h29, 6'h2a, 6'h2b, 6'h2e: return OP_STORE;
            default:                           return OP_ALU;
        endcase
    endfunction

endpackage

// ==== hdl/inst_rom.sv ====
`timescale 1ns/10ps
`include "fetch_config.svh"

module inst_rom import fetch_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  apb_req_t           apb_req,
    output apb_rsp_t           apb_rsp,
    input  logic               req_valid,
    input  logic [`ADDR_W-1:0] req_pc,
    output logic               resp_valid,
    output fifo_entry_t        resp_line1,
    output fifo_entry_t        resp_line2
);

    localparam int IDX_W = $clog2(`ROM_WORDS);
    localparam logic [`ADDR_W-1:0] ROM_BYTES = `ROM_WORDS * 4;

    logic [31:0]        mem [`ROM_WORDS];
    logic               apb_access;
    logic               apb_in_range;
    logic [`ADDR_W-1:0] pc2;
    logic               in1, in2;

    // zero wait states, access phase completes at once
    assign apb_access      = apb_req.psel && apb_req.penable;
    assign apb_in_range    = apb_req.paddr < ROM_BYTES;
    assign apb_rsp.pready  = apb_access;
    assign apb_rsp.pslverr = apb_access && !apb_in_range;

    always_ff @(posedge clk) begin
        if (apb_access && apb_req.pwrite && apb_in_range)
            mem[apb_req.paddr[IDX_W+1:2]] <= apb_req.pwdata;
    end

    assign pc2 = req_pc + `ADDR_W'(4);
    assign in1 = req_pc < ROM_BYTES;
    assign in2 = in1 && (pc2 < ROM_BYTES);  // second word may cross the top

    always_ff @(posedge clk) begin
        if (rst)
            resp_valid <= 1'b0;
        else
            resp_valid <= req_valid;
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            resp_line1 <= '{invalid: !in1, addr: req_pc, data: in1 ? mem[req_pc[IDX_W+1:2]] : 32'h0};
            resp_line2 <= '{invalid: !in2, addr: pc2, data: in2 ? mem[pc2[IDX_W+1:2]] : 32'h0};
        end
    end

endmodule

// ==== hdl/fetch_pc_gen.sv ====
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetch_pc_gen import fetch_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_en,
    input  logic               full,
    input  redirect_t          redirect,
    output logic               req_valid,
    output logic [`ADDR_W-1:0] req_pc,
    input  logic               resp_valid,
    output logic               stale
);

    logic [`ADDR_W-1:0] pc;
    logic               epoch;    // path tag, flips on every redirect
    logic               req_tag;  // path of the request in flight

    // hold while the queue has no room for a pair
    assign req_valid = fetch_en && !full;
    assign req_pc    = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (redirect.valid) begin
            pc <= redirect.target;
        end else if (req_valid) begin
            pc <= pc + `ADDR_W'(8);
        end
    end

    always_ff @(posedge clk) begin
        if (rst)
            epoch <= 1'b0;
        else if (redirect.valid)
            epoch <= !epoch;
    end

    always_ff @(posedge clk) begin
        if (rst)
            req_tag <= 1'b0;
        else if (req_valid)
            req_tag <= epoch;  // old path if issued in the redirect cycle
    end

    // response in the redirect cycle is old path too
    assign stale = resp_valid && (redirect.valid || (req_tag != epoch));

endmodule

// ==== hdl/inst_fifo.sv ====
`timescale 1ns/10ps
`include "fetch_config.svh"

module inst_fifo import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  redirect_t   flush,
    input  logic        stale,
    input  logic        write_en1,
    input  logic        write_en2,
    input  fifo_entry_t write_line1,
    input  fifo_entry_t write_line2,
    input  logic        read_en1,
    input  logic        read_en2,
    input  logic        master_is_branch,
    output fifo_entry_t head1,
    output fifo_entry_t head2,
    output logic        head1_valid,
    output logic        head2_valid,
    output logic        full,
    output logic        issue_delayslot
);

    localparam int PTR_W = $clog2(`FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    fifo_entry_t lines [`FIFO_DEPTH];
    fifo_entry_t ds_line;

    logic [PTR_W-1:0] write_pointer;
    logic [PTR_W-1:0] read_pointer;
    logic [CNT_W-1:0] data_count;

    logic             wr1, wr2;
    logic             rd1, rd2;
    logic [CNT_W-1:0] wr_n, rd_n;
    logic [CNT_W-1:0] count_pend;

    logic ds_valid;  // delay slot waits in ds_line
    logic ds_pend;   // delay slot still to come from a stale response
    logic ds_arm;
    logic ds_take_head;
    logic ds_take_write;

    // stale writes never reach the buffer
    assign wr1 = write_en1 && !stale && !flush.valid;
    assign wr2 = write_en2 && !stale && !flush.valid;

    // pops hit the buffer only when the delay slot is not in front
    assign rd1 = read_en1 && !ds_valid && (data_count != '0);
    assign rd2 = read_en2 && rd1 && (data_count > CNT_W'(1));

    assign wr_n = CNT_W'(wr1) + CNT_W'(wr2);
    assign rd_n = CNT_W'(rd1) + CNT_W'(rd2);

    // the response landing this cycle is not counted yet
    assign count_pend = data_count + wr_n;
    assign full       = count_pend > CNT_W'(`FIFO_DEPTH - 2);

    always_comb begin
        if (ds_valid) begin
            head1       = ds_line;
            head1_valid = 1'b1;
            head2       = lines[read_pointer];
            head2_valid = 1'b0;  // delay slot issues alone
        end else begin
            head1       = lines[read_pointer];
            head1_valid = data_count != '0;
            head2       = lines[read_pointer + PTR_W'(1)];
            head2_valid = data_count > CNT_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (wr1)
            lines[write_pointer] <= write_line1;
        if (wr2)
            lines[write_pointer + PTR_W'(wr1)] <= write_line2;
    end

    always_ff @(posedge clk) begin
        if (rst || flush.valid) begin
            write_pointer <= '0;
            read_pointer  <= '0;
            data_count    <= '0;
        end else begin
            write_pointer <= write_pointer + PTR_W'(wr_n);
            read_pointer  <= read_pointer + PTR_W'(rd_n);
            data_count    <= data_count + wr_n - rd_n;
        end
    end

    // branch left the queue without its slot
    always_ff @(posedge clk) begin
        if (rst)
            issue_delayslot <= 1'b0;
        else if (read_en1 && head1_valid)
            issue_delayslot <= master_is_branch && !read_en2;
    end

    // slot not issued in the flush cycle itself
    assign ds_arm = flush.valid && issue_delayslot && !read_en1 && !ds_valid && !ds_pend;

    assign ds_take_head  = ds_arm && (data_count != '0);
    assign ds_take_write = ((ds_arm && data_count == '0) || ds_pend) && write_en1 && stale;

    always_ff @(posedge clk) begin
        if (rst) begin
            ds_valid <= 1'b0;
            ds_pend  <= 1'b0;
        end else if (ds_take_head || ds_take_write) begin
            ds_valid <= 1'b1;
            ds_pend  <= 1'b0;
        end else if (ds_arm) begin
            ds_pend  <= 1'b1;  // queue empty, slot still in flight
        end else if (ds_valid && read_en1) begin
            ds_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ds_take_head)
            ds_line <= lines[read_pointer];
        else if (ds_take_write)
            ds_line <= write_line1;
    end

endmodule

// ==== hdl/issue_ctrl.sv ====
`timescale 1ns/10ps

module issue_ctrl import fetch_pkg::*; (
    input  fifo_entry_t head1,
    input  fifo_entry_t head2,
    input  logic        head1_valid,
    input  logic        head2_valid,
    input  logic        issue_stall,
    output logic        read_en1,
    output logic        read_en2,
    output logic        master_is_branch,
    output issue_slot_t slot1,
    output issue_slot_t slot2
);

    op_class_e  master_class;
    logic [5:0] master_op;
    logic [4:0] master_dst;
    logic       master_writes;
    logic [4:0] slave_rs;
    logic [4:0] slave_rt;
    logic       raw_hazard;
    logic       pair;

    assign master_class = op_class_of(head1.data);
    assign master_op    = head1.data[31:26];
    assign slave_rs     = head2.data[25:21];
    assign slave_rt     = head2.data[20:16];

    assign master_is_branch = head1_valid &&
                              (master_class == OP_BRANCH || master_class == OP_JUMP);

    // destination register of the master
    always_comb begin
        master_writes = 1'b0;
        master_dst    = head1.data[20:16];
        if (master_op == 6'h00) begin
            master_writes = master_class == OP_ALU;  // r-type writes rd
            master_dst    = head1.data[15:11];
        end else if (master_op[5:3] == 3'b001 || master_class == OP_LOAD) begin
            master_writes = 1'b1;  // immediate alu and loads write rt
        end
    end

    // r0 never creates a dependence
    assign raw_hazard = master_writes && (master_dst != 5'd0) &&
                        (slave_rs == master_dst || slave_rt == master_dst);

    assign pair = head2_valid && !master_is_branch && !raw_hazard;

    assign read_en1 = head1_valid && !issue_stall;
    assign read_en2 = read_en1 && pair;

    assign slot1 = '{valid: read_en1, entry: head1};
    assign slot2 = '{valid: read_en2, entry: head2};

endmodule

// ==== hdl/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        fetch_en,
    input  logic        issue_stall,
    input  redirect_t   redirect,
    input  apb_req_t    prog_apb,
    output apb_rsp_t    prog_rsp,
    output issue_slot_t slot1,
    output issue_slot_t slot2
);

    logic        req_valid;
    logic [31:0] req_pc;
    logic        resp_valid;
    fifo_entry_t resp_line1;
    fifo_entry_t resp_line2;
    logic        stale;
    logic        full;

    fifo_entry_t head1;
    fifo_entry_t head2;
    logic        head1_valid;
    logic        head2_valid;
    logic        read_en1;
    logic        read_en2;
    logic        master_is_branch;

    inst_rom u_rom (
        .clk        (clk),
        .rst        (rst),
        .apb_req    (prog_apb),
        .apb_rsp    (prog_rsp),
        .req_valid  (req_valid),
        .req_pc     (req_pc),
        .resp_valid (resp_valid),
        .resp_line1 (resp_line1),
        .resp_line2 (resp_line2)
    );

    fetch_pc_gen u_pc_gen (
        .clk        (clk),
        .rst        (rst),
        .fetch_en   (fetch_en),
        .full       (full),
        .redirect   (redirect),
        .req_valid  (req_valid),
        .req_pc     (req_pc),
        .resp_valid (resp_valid),
        .stale      (stale)
    );

    // both words of a response are written together
    inst_fifo u_fifo (
        .clk              (clk),
        .rst              (rst),
        .flush            (redirect),
        .stale            (stale),
        .write_en1        (resp_valid),
        .write_en2        (resp_valid),
        .write_line1      (resp_line1),
        .write_line2      (resp_line2),
        .read_en1         (read_en1),
        .read_en2         (read_en2),
        .master_is_branch (master_is_branch),
        .head1            (head1),
        .head2            (head2),
        .head1_valid      (head1_valid),
        .head2_valid      (head2_valid),
        .full             (full),
        .issue_delayslot  ()
    );

    issue_ctrl u_issue (
        .head1            (head1),
        .head2            (head2),
        .head1_valid      (head1_valid),
        .head2_valid      (head2_valid),
        .issue_stall      (issue_stall),
        .read_en1         (read_en1),
        .read_en2         (read_en2),
        .master_is_branch (master_is_branch),
        .slot1            (slot1),
        .slot2            (slot2)
    );

endmodule

// ==== bench/fetch_tb.sv ====
`timescale 1ns/10ps
`include "fetch_config.svh"

module fetch_tb import fetch_pkg::*; ();

    localparam int N_REDIR = 12;
    localparam int TIMEOUT = 8 * `ROM_WORDS + N_REDIR * 200 + 400;  // issue, stalls, redirects
    localparam logic [31:0] ROM_BYTES = `ROM_WORDS * 4;

    logic        clk;
    logic        rst;
    logic        fetch_en;
    logic        issue_stall;
    redirect_t   redirect;
    apb_req_t    prog_apb;
    apb_rsp_t    prog_rsp;
    issue_slot_t slot1;
    issue_slot_t slot2;

    logic [31:0] prog [`ROM_WORDS];
    integer      seed = 32'h07a73e1e;
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycles = 0;
    int          issued = 0;
    int          pairs = 0;
    int          alone_branches = 0;
    int          stall_left = 0;

    // reference model state
    logic [31:0] next_addr;
    logic [31:0] fetch_base;  // fetched pairs start here, 8 bytes apart
    logic [31:0] ds_addr;
    logic [31:0] branch_addr;
    logic        pend_ds;
    logic        last_alone_branch;
    logic        br_seen;

    fetch_top dut (
        .clk         (clk),
        .rst         (rst),
        .fetch_en    (fetch_en),
        .issue_stall (issue_stall),
        .redirect    (redirect),
        .prog_apb    (prog_apb),
        .prog_rsp    (prog_rsp),
        .slot1       (slot1),
        .slot2       (slot2)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("timeout: test did not finish within %0d cycles", TIMEOUT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic fifo_entry_t expected_entry(input logic [31:0] addr);
        fifo_entry_t e;
        e.invalid = addr >= ROM_BYTES;
        e.addr    = addr;
        e.data    = e.invalid ? 32'h0 : prog[addr[$clog2(`ROM_WORDS)+1:2]];
        return e;
    endfunction

    function automatic logic is_control(input logic [31:0] inst);
        op_class_e c;
        c = op_class_of(inst);
        return c == OP_BRANCH || c == OP_JUMP;
    endfunction

    // may the slave issue alongside the master
    function automatic logic expect_pair(input logic [31:0] m, input logic [31:0] s);
        logic [4:0] dst;
        logic       writes;
        if (is_control(m))
            return 1'b0;
        writes = 1'b0;
        dst    = m[20:16];
        if (m[31:26] == 6'h00) begin
            writes = 1'b1;  // r-type, rd
            dst    = m[15:11];
        end else if (m[31:29] == 3'b001 || op_class_of(m) == OP_LOAD) begin
            writes = 1'b1;
        end
        if (!writes || dst == 5'd0)
            return 1'b1;  // r0 never written
        return s[25:21] != dst && s[20:16] != dst;
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = $random(seed);
        return 5'(r % 32'd31 + 32'd1);
    endfunction

    task automatic gen_program();
        logic [31:0] r;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  prev_dst;
        prev_dst = 5'd1;
        for (int i = 0; i < `ROM_WORDS; i++) begin
            r  = $random(seed);
            rs = rand_reg();
            rt = rand_reg();
            rd = rand_reg();
            if (r[9:8] == 2'b00)
                rs = prev_dst;  // forced raw hazard
            case (r[2:0])
                3'd0, 3'd1: begin
                    prog[i]  = {6'h00, rs, rt, rd, 5'd0, 6'h21};
                    prev_dst = rd;
                end
                3'd3: begin
                    prog[i]  = {6'h23, rs, rt, r[31:16]};
                    prev_dst = rt;
                end
                3'd4: prog[i] = {6'h2b, rs, rt, r[31:16]};
                3'd5: prog[i] = {6'h04, rs, rt, r[31:16]};
                3'd6: prog[i] = {6'h02, r[31:6]};
                default: begin
                    prog[i]  = {6'h08, rs, rt, r[31:16]};
                    prev_dst = rt;
                end
            endcase
            if (i % 16 == 15)
                prog[i] = {6'h05, rs, rt, r[31:16]};  // regular branch
        end
    endtask

    task automatic check_slot(input issue_slot_t got, input issue_slot_t exp, input string what);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t %s: got v%b inv%b %h:%h, expected v%b inv%b %h:%h", $time,
                     what, got.valid, got.entry.invalid, got.entry.addr, got.entry.data,
                     exp.valid, exp.entry.invalid, exp.entry.addr, exp.entry.data);
        end
    endtask

    task automatic check_apb(input apb_rsp_t got, input apb_rsp_t exp, input logic [31:0] addr);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t apb write %h: got pready %b pslverr %b, expected %b %b",
                     $time, addr, got.pready, got.pslverr, exp.pready, exp.pslverr);
        end
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data, input logic err);
        apb_rsp_t exp;
        exp = '{pready: 1'b1, pslverr: err};
        @(posedge clk);
        prog_apb <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        prog_apb.penable <= 1'b1;
        @(negedge clk);
        check_apb(prog_rsp, exp, addr);
        @(posedge clk);
        prog_apb <= '0;
    endtask

    task automatic drive_stall();
        logic [31:0] r;
        r = $random(seed);
        if (stall_left > 0) begin
            stall_left--;
            issue_stall <= 1'b1;
        end else if (r[3:0] == 4'd0) begin
            stall_left = int'(r[6:4]);  // stretch up to 8 cycles
            issue_stall <= 1'b1;
        end else begin
            issue_stall <= 1'b0;
        end
    endtask

    task automatic do_redirect(input logic [31:0] target);
        issue_stall <= 1'b1;  // nothing issues in the flush cycle
        redirect    <= '{valid: 1'b1, target: target};
        @(posedge clk);
        redirect    <= '0;
        issue_stall <= 1'b0;
        stall_left = 0;
    endtask

    always @(negedge clk) begin
        fifo_entry_t e1;
        fifo_entry_t e2;
        logic        from_ds;
        if (!rst) begin
            if (redirect.valid) begin
                pend_ds    = last_alone_branch;
                ds_addr    = branch_addr + 32'd4;
                next_addr  = redirect.target;
                fetch_base = redirect.target;
            end
            if (issue_stall && (slot1.valid || slot2.valid)) begin
                other_errors++;
                $display("slot issued at %0t while issue was stalled", $time);
            end
            if (slot2.valid && !slot1.valid) begin
                other_errors++;
                $display("slot2 issued without slot1 at %0t", $time);
            end
            if (slot1.valid) begin
                from_ds = pend_ds;
                if (pend_ds) begin
                    e1      = expected_entry(ds_addr);
                    pend_ds = 1'b0;
                end else begin
                    e1        = expected_entry(next_addr);
                    next_addr = next_addr + 32'd4;
                end
                e2 = expected_entry(next_addr);
                check_slot(slot1, '{valid: 1'b1, entry: e1}, "slot1");
                if (slot2.valid) begin
                    if (from_ds || !expect_pair(e1.data, e2.data)) begin
                        other_errors++;
                        $display("pair issued at %0t where a single issue was due", $time);
                    end
                    check_slot(slot2, '{valid: 1'b1, entry: e2}, "slot2");
                    next_addr = next_addr + 32'd4;
                    pairs++;
                end else if (!from_ds && ((e1.addr - fetch_base) & 32'd7) == 32'd0 &&
                             expect_pair(e1.data, e2.data)) begin
                    // both words of one response are queued together
                    other_errors++;
                    $display("single issue at %0t where a queued pair was due", $time);
                end
                last_alone_branch = is_control(e1.data) && !slot2.valid;
                if (last_alone_branch) begin
                    branch_addr = e1.addr;
                    alone_branches++;
                end
                // a branch sitting in a delay slot has no defined slot of its own
                br_seen = !from_ds &&
                          (is_control(e1.data) || (slot2.valid && is_control(e2.data)));
                issued += 1 + int'(slot2.valid);
            end
        end
    end

    initial begin
        logic [31:0] rv;
        logic [31:0] word;
        int          mark;
        clk               = 1'b0;
        rst               = 1'b1;
        fetch_en          = 1'b0;
        issue_stall       = 1'b0;
        redirect          = '0;
        prog_apb          = '0;
        next_addr         = `RESET_PC;
        fetch_base        = `RESET_PC;
        ds_addr           = '0;
        branch_addr       = '0;
        pend_ds           = 1'b0;
        last_alone_branch = 1'b0;
        br_seen           = 1'b0;
        gen_program();
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < `ROM_WORDS; i++)
            apb_write(32'(i * 4), prog[i], 1'b0);
        apb_write(ROM_BYTES + 32'd8, 32'hdead_beef, 1'b1);  // outside the memory

        // sequential run across the top of memory
        @(posedge clk);
        fetch_en <= 1'b1;
        while (next_addr < ROM_BYTES + 32'd16) begin
            @(posedge clk);
            drive_stall();
        end
        @(posedge clk);
        do_redirect(32'h0);

        // redirect right after each branch issue
        for (int r = 0; r < N_REDIR; r++) begin
            br_seen = 1'b0;
            @(posedge clk);
            while (!br_seen) begin
                drive_stall();
                @(posedge clk);
            end
            rv   = $random(seed);
            word = rv % 32'd192;
            do_redirect({word[29:0], 2'b00});
        end

        mark = issued;
        while (issued < mark + 8) begin
            @(posedge clk);
            drive_stall();
        end
        repeat (4) @(posedge clk);

        if (pairs == 0) begin
            other_errors++;
            $display("no instruction pair was ever issued");
        end
        if (alone_branches == 0) begin
            other_errors++;
            $display("no branch was ever issued alone");
        end
        $display("done: %0d value errors, %0d other errors, %0d issued, %0d pairs",
                 value_errors, other_errors, issued, pairs);
        if (value_errors + other_errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+hdl
hdl/fetch_pkg.sv
hdl/inst_rom.sv
hdl/fetch_pc_gen.sv
hdl/inst_fifo.sv
hdl/issue_ctrl.sv
hdl/fetch_top.sv
bench/fetch_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module fetch_tb -f project.f \
    --Mdir obj_dir -o fetch_sim &&
./obj_dir/fetch_sim | tee /dev/stderr | grep -q "RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
